// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_dmac_request_path
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
PASS    := *** PASSED ***

.PHONY: all run clean

all: run

# The binary is rebuilt only when a source or the file list changes.
$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS)'

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
+incdir+include
verilog/dmac_pkg.sv
verilog/dmac_request_queue.sv
verilog/dmac_2d_transfer.sv
verilog/dmac_burst_splitter.sv
verilog/dmac_request_path.sv
testbench/tb_dmac_request_path.sv

// ==== include/dmac_macros.svh ====
`ifndef DMAC_MACROS_SVH
`define DMAC_MACROS_SVH

// Source and destination use the same beat size, so no width conversion is done.
`define DMAC_BEAT_WIDTH 3

// Row length, row count and strides.
`define DMAC_LENGTH_WIDTH 24

// --------------------------------------------------
// Burst and queue limits
// --------------------------------------------------
`define DMAC_MAX_BURST_BEATS 16
`define DMAC_QUEUE_DEPTH 4

// Four rows or bursts may be outstanding at a time.
`define DMAC_ID_WIDTH 2

`endif

// ==== testbench/dmac_input.txt ====
# name mode count dest src x_length y_length dest_stride src_stride sync bursts
# Hex fields are beat addresses, byte lengths minus one and byte strides; copies add 0x100 beats.
single_16_beats none 1 00001000 00002000 00007f 000000 000000 000000 1 1
single_1_beat none 1 00001100 00002100 000007 000000 000000 000000 0 1
single_low_bits none 1 00001200 00002200 00003d 000000 000000 000000 1 1
long_row_64 none 1 00003000 00004000 0001ff 000000 000000 000000 1 4
long_row_73 none 1 00003100 00004100 000247 000000 000000 000000 0 5
long_row_17 none 1 00003200 00004200 000087 000000 000000 000000 1 2
multi_row none 1 00005000 00006000 00003f 000003 000400 000200 1 4
multi_row_long none 1 00005100 00006100 0000ff 000002 001000 000800 1 6
stride_low_bits none 1 00005200 00006200 00001f 000001 000107 0000ff 1 2
addr_wrap none 1 1ffffff8 1ffffff0 0000ff 000001 000080 000080 1 4
eot_back_to_back none 3 00007000 00008000 0000ff 000001 000100 000100 1 4
random_b2b random 8 00009000 0000a000 00017f 000002 000400 000400 1 9
random_short_rows random 5 0000b000 0000c000 000007 000005 000040 000080 0 6
random_long random 3 0000d000 0000e000 0007ff 000001 000800 000800 1 32
full_queue full 6 00010000 00011000 00003f 000000 000000 000000 1 1
full_queue_rows full 6 00012000 00013000 0000ff 000001 000200 000200 1 4
after_full none 2 00014000 00015000 000047 000000 000000 000000 1 1

// ==== testbench/tb_dmac_request_path.sv ====
`include "dmac_macros.svh"

module tb_dmac_request_path;

	timeunit 1ns;
	timeprecision 1ps;

	logic req_aclk = 1'b0;
	logic req_aresetn;
	logic req_valid;
	logic req_ready;
	dmac_pkg::dmac_addr_t req_dest_address;
	dmac_pkg::dmac_addr_t req_src_address;
	dmac_pkg::dmac_length_t req_x_length;
	dmac_pkg::dmac_length_t req_y_length;
	dmac_pkg::dmac_length_t req_dest_stride;
	dmac_pkg::dmac_length_t req_src_stride;
	logic req_sync_transfer_start;
	logic req_eot;
	logic burst_valid;
	logic burst_ready = 1'b0;
	dmac_pkg::dmac_addr_t burst_dest_address;
	dmac_pkg::dmac_addr_t burst_src_address;
	dmac_pkg::dmac_beats_t burst_beats;
	logic burst_sync_transfer_start;
	logic burst_done = 1'b0;

	// Test table from the input file.
	string t_name [$];
	string t_mode [$];
	int t_count [$];
	dmac_pkg::dmac_addr_t t_dest [$];
	dmac_pkg::dmac_addr_t t_src [$];
	dmac_pkg::dmac_length_t t_x [$];
	dmac_pkg::dmac_length_t t_y [$];
	dmac_pkg::dmac_length_t t_ds [$];
	dmac_pkg::dmac_length_t t_ss [$];
	logic t_sync [$];
	int t_bursts [$];

	// Expected bursts, in issue order.
	dmac_pkg::dmac_addr_t exp_dest [$];
	dmac_pkg::dmac_addr_t exp_src [$];
	dmac_pkg::dmac_beats_t exp_beats [$];
	logic exp_sync [$];
	logic exp_last [$];

	int pend_due [$]; // Cycle from which the mover may complete the burst.
	logic pend_last [$];
	int eot_due [$];
	logic done_last = 1'b0;

	string test_name = "";
	int test_errors = 0;
	int pass_count = 0;
	int fail_count = 0;
	int bursts_seen = 0;
	int eot_count = 0;
	int cycle = 0;
	int limit = 0;
	logic rand_mode = 1'b0;
	logic stall_full = 1'b0;
	logic saw_full = 1'b0;
	int stall_cycles = 0;

	always #10 req_aclk = ~req_aclk;

	dmac_request_path dmac_request_path_inst (
		.req_aclk(req_aclk),
		.req_aresetn(req_aresetn),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_dest_address(req_dest_address),
		.req_src_address(req_src_address),
		.req_x_length(req_x_length),
		.req_y_length(req_y_length),
		.req_dest_stride(req_dest_stride),
		.req_src_stride(req_src_stride),
		.req_sync_transfer_start(req_sync_transfer_start),
		.req_eot(req_eot),
		.burst_valid(burst_valid),
		.burst_ready(burst_ready),
		.burst_dest_address(burst_dest_address),
		.burst_src_address(burst_src_address),
		.burst_beats(burst_beats),
		.burst_sync_transfer_start(burst_sync_transfer_start),
		.burst_done(burst_done)
	);

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	task automatic check_addr(input string what, input dmac_pkg::dmac_addr_t expected,
		input dmac_pkg::dmac_addr_t actual);
		if (actual !== expected) begin
			$display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_beats(input string what, input dmac_pkg::dmac_beats_t expected,
		input dmac_pkg::dmac_beats_t actual);
		if (actual !== expected) begin
			$display("ERR %s %s expected %0d actual %0d", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERR %s %s expected %b actual %b", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		if (actual != expected) begin
			$display("ERR %s %s expected %0d actual %0d", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s: %s", test_name, what);
		test_errors++;
	endtask

	task automatic close_test();
		if (test_errors == 0)
			pass_count++;
		else
			fail_count++;
		$display("%-20s %s, %0d bursts, %0d errors", test_name,
			(test_errors == 0) ? "ok" : "failed", bursts_seen, test_errors);
	endtask

	// Walks rows and bursts of one descriptor and queues the bursts it should give.
	function automatic int build_expected(input dmac_pkg::dmac_addr_t dest,
		input dmac_pkg::dmac_addr_t src, input dmac_pkg::dmac_length_t x_length,
		input dmac_pkg::dmac_length_t y_length, input dmac_pkg::dmac_length_t dest_stride,
		input dmac_pkg::dmac_length_t src_stride, input logic sync);
		dmac_pkg::dmac_addr_t row_dest;
		dmac_pkg::dmac_addr_t row_src;
		int r;
		int left;
		int take;
		int n;
		int total;
		row_dest = dest;
		row_src = src;
		total = 0;
		for (r = 0; r <= int'(y_length); r++) begin
			left = int'(x_length >> `DMAC_BEAT_WIDTH) + 1; // Beats in the row.
			n = 0;
			while (left > 0) begin
				take = (left > `DMAC_MAX_BURST_BEATS) ? `DMAC_MAX_BURST_BEATS : left;
				exp_dest.push_back(row_dest + dmac_pkg::dmac_addr_t'(n * `DMAC_MAX_BURST_BEATS));
				exp_src.push_back(row_src + dmac_pkg::dmac_addr_t'(n * `DMAC_MAX_BURST_BEATS));
				exp_beats.push_back(dmac_pkg::dmac_beats_t'(take - 1));
				exp_sync.push_back(sync && r == 0 && n == 0);
				exp_last.push_back(1'b0);
				left -= take;
				n++;
				total++;
			end
			row_dest += dmac_pkg::dmac_addr_t'(dest_stride >> `DMAC_BEAT_WIDTH);
			row_src += dmac_pkg::dmac_addr_t'(src_stride >> `DMAC_BEAT_WIDTH);
		end
		exp_last[exp_last.size() - 1] = 1'b1;
		return total;
	endfunction

	task automatic send_desc(input dmac_pkg::dmac_addr_t dest, input dmac_pkg::dmac_addr_t src,
		input dmac_pkg::dmac_length_t x_length, input dmac_pkg::dmac_length_t y_length,
		input dmac_pkg::dmac_length_t dest_stride, input dmac_pkg::dmac_length_t src_stride,
		input logic sync);
		req_valid = 1'b1;
		req_dest_address = dest;
		req_src_address = src;
		req_x_length = x_length;
		req_y_length = y_length;
		req_dest_stride = dest_stride;
		req_src_stride = src_stride;
		req_sync_transfer_start = sync;
		do
			@(posedge req_aclk);
		while (!req_ready);
		@(negedge req_aclk);
		req_valid = 1'b0;
	endtask

	// --------------------------------------------------
	// Burst monitor and data mover
	// --------------------------------------------------
	always @(posedge req_aclk) begin
		cycle++;
		if (burst_valid && burst_ready) begin
			bursts_seen++;
			if (exp_dest.size() == 0) begin
				report_failure("a burst was issued while none was expected");
			end else begin
				check_addr("burst_dest_address", exp_dest.pop_front(), burst_dest_address);
				check_addr("burst_src_address", exp_src.pop_front(), burst_src_address);
				check_beats("burst_beats", exp_beats.pop_front(), burst_beats);
				check_bit("burst_sync_transfer_start", exp_sync.pop_front(),
					burst_sync_transfer_start);
				pend_last.push_back(exp_last.pop_front());
				pend_due.push_back(cycle + int'($urandom_range(0, 7)));
			end
		end
		if (req_eot) begin
			eot_count++;
			if (eot_due.size() == 0) begin
				report_failure("req_eot came before any descriptor finished");
			end else begin
				check_count("req_eot cycle", eot_due[0], cycle);
				void'(eot_due.pop_front());
			end
		end
		if (burst_done && done_last)
			eot_due.push_back(cycle + 2); // Row done, then end of transfer.
		if (stall_full) begin
			stall_cycles++;
			if (!req_ready)
				saw_full = 1'b1;
			if (stall_cycles >= 40)
				stall_full = 1'b0; // Six descriptors fill the queue well within this.
		end
	end

	always @(negedge req_aclk) begin
		burst_done = 1'b0;
		done_last = 1'b0;
		if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
			burst_done = 1'b1;
			done_last = pend_last.pop_front();
			void'(pend_due.pop_front());
		end
		burst_ready = (pend_due.size() < 4) && !stall_full &&
			(!rand_mode || $urandom_range(0, 3) != 0);
	end

	initial begin
		wait (limit != 0);
		while (cycle <= limit)
			@(negedge req_aclk);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("*** FAILED ***");
		$finish;
	end

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	initial begin
		int fd;
		int n;
		int i;
		int k;
		int nb;
		int count;
		int sync_in;
		int total;
		string line;
		string name;
		string mode;
		dmac_pkg::dmac_addr_t dest;
		dmac_pkg::dmac_addr_t src;
		dmac_pkg::dmac_addr_t offset;
		dmac_pkg::dmac_length_t x;
		dmac_pkg::dmac_length_t y;
		dmac_pkg::dmac_length_t ds;
		dmac_pkg::dmac_length_t ss;

		void'($urandom(32'h08cc_d427));
		req_aresetn = 1'b0;
		req_valid = 1'b0;
		req_dest_address = '0;
		req_src_address = '0;
		req_x_length = '0;
		req_y_length = '0;
		req_dest_stride = '0;
		req_src_stride = '0;
		req_sync_transfer_start = 1'b0;
		total = 0;

		fd = $fopen("testbench/dmac_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open testbench/dmac_input.txt");
			fail_count++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line.substr(0, 0) == "#")
					continue;
				n = $sscanf(line, "%s %s %d %h %h %h %h %h %h %d %d", name, mode, count,
					dest, src, x, y, ds, ss, sync_in, nb);
				if (n != 11) begin
					$display("Input line could not be read: %s", line);
					fail_count++;
				end else begin
					t_name.push_back(name);
					t_mode.push_back(mode);
					t_count.push_back(count);
					t_dest.push_back(dest);
					t_src.push_back(src);
					t_x.push_back(x);
					t_y.push_back(y);
					t_ds.push_back(ds);
					t_ss.push_back(ss);
					t_sync.push_back(sync_in != 0);
					t_bursts.push_back(nb);
					total += count * nb;
				end
			end
			$fclose(fd);
		end
		limit = total * 20 + 200;

		repeat (8) @(posedge req_aclk);
		@(negedge req_aclk);
		req_aresetn = 1'b1;
		@(negedge req_aclk);

		test_name = "reset_state";
		check_bit("req_ready", 1'b1, req_ready);
		check_bit("burst_valid", 1'b0, burst_valid);
		check_bit("req_eot", 1'b0, req_eot);
		close_test();

		for (i = 0; i < t_name.size(); i++) begin
			test_name = t_name[i];
			test_errors = 0;
			bursts_seen = 0;
			eot_count = 0;
			saw_full = 1'b0;
			stall_cycles = 0;
			if (t_mode[i] != "none" && t_mode[i] != "random" && t_mode[i] != "full")
				report_failure("unknown back-pressure mode in the input file");
			rand_mode = t_mode[i] == "random";
			stall_full = t_mode[i] == "full"; // Held for a fixed number of cycles.
			for (k = 0; k < t_count[i]; k++) begin
				offset = dmac_pkg::dmac_addr_t'(k * 256);
				nb = build_expected(t_dest[i] + offset, t_src[i] + offset, t_x[i], t_y[i],
					t_ds[i], t_ss[i], t_sync[i]);
				check_count("bursts per descriptor", t_bursts[i], nb);
			end
			for (k = 0; k < t_count[i]; k++) begin
				offset = dmac_pkg::dmac_addr_t'(k * 256);
				send_desc(t_dest[i] + offset, t_src[i] + offset, t_x[i], t_y[i],
					t_ds[i], t_ss[i], t_sync[i]);
			end
			while (eot_count < t_count[i])
				@(negedge req_aclk);
			repeat (4) @(negedge req_aclk); // Room for a stray burst or eot.

			check_count("req_eot count", t_count[i], eot_count);
			check_count("burst count", t_count[i] * t_bursts[i], bursts_seen);
			if (exp_dest.size() != 0)
				report_failure("some expected bursts were never issued");
			if (eot_due.size() != 0)
				report_failure("a descriptor finished without its req_eot");
			if (t_mode[i] == "full")
				check_bit("req_ready low with the queue full", 1'b1, saw_full);
			exp_dest.delete();
			exp_src.delete();
			exp_beats.delete();
			exp_sync.delete();
			exp_last.delete();
			rand_mode = 1'b0;
			stall_full = 1'b0;
			close_test();
		end

		$display("Closing counts: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== verilog/dmac_2d_transfer.sv ====
`include "dmac_macros.svh"

module dmac_2d_transfer (
	input logic req_aclk,
	input logic req_aresetn,

	input logic desc_valid,
	output logic desc_ready,
	input dmac_pkg::dmac_addr_t desc_dest_address,
	input dmac_pkg::dmac_addr_t desc_src_address,
	input dmac_pkg::dmac_length_t desc_x_length,
	input dmac_pkg::dmac_length_t desc_y_length,
	input dmac_pkg::dmac_length_t desc_dest_stride,
	input dmac_pkg::dmac_length_t desc_src_stride,
	input logic desc_sync_transfer_start,

	output logic row_valid,
	input logic row_ready,
	output dmac_pkg::dmac_addr_t row_dest_address,
	output dmac_pkg::dmac_addr_t row_src_address,
	output dmac_pkg::dmac_length_t row_length,
	output logic row_sync_transfer_start,

	input logic row_done,
	output logic req_eot
);

	dmac_pkg::xfer_state_e state;

	dmac_pkg::dmac_addr_t dest_address;
	dmac_pkg::dmac_addr_t src_address;
	dmac_pkg::dmac_length_t x_length;
	dmac_pkg::dmac_length_t y_length;
	dmac_pkg::dmac_length_t dest_stride;
	dmac_pkg::dmac_length_t src_stride;
	logic sync_start;

	// --------------------------------------------------
	// Rows in flight
	// --------------------------------------------------
	dmac_pkg::dmac_id_t issue_id;
	dmac_pkg::dmac_id_t done_id;
	logic last_row [2**`DMAC_ID_WIDTH];
	logic [`DMAC_ID_WIDTH:0] inflight;
	logic row_accept;

	// Rows stop while every table entry is waiting for its row_done.
	assign row_valid = (state == dmac_pkg::XFER_ROWS) && !inflight[`DMAC_ID_WIDTH];
	assign desc_ready = state == dmac_pkg::XFER_IDLE;
	assign row_accept = row_valid && row_ready;

	assign row_dest_address = dest_address;
	assign row_src_address = src_address;
	assign row_length = x_length;
	assign row_sync_transfer_start = sync_start;

	always_ff @(posedge req_aclk) begin
		if (desc_valid && desc_ready) begin
			dest_address <= desc_dest_address;
			src_address <= desc_src_address;
			x_length <= desc_x_length;
			y_length <= desc_y_length;
			dest_stride <= desc_dest_stride;
			src_stride <= desc_src_stride;
		end else if (row_accept) begin
			dest_address <= dest_address +
				dmac_pkg::dmac_addr_t'(dest_stride[`DMAC_LENGTH_WIDTH-1:`DMAC_BEAT_WIDTH]);
			src_address <= src_address +
				dmac_pkg::dmac_addr_t'(src_stride[`DMAC_LENGTH_WIDTH-1:`DMAC_BEAT_WIDTH]);
			y_length <= y_length - 1'b1;
		end
		if (row_accept)
			last_row[issue_id] <= y_length == '0;
	end

	always_ff @(posedge req_aclk) begin
		if (!req_aresetn) begin
			state <= dmac_pkg::XFER_IDLE;
			sync_start <= 1'b0;
		end else begin
			case (state)
				dmac_pkg::XFER_IDLE: begin
					if (desc_valid) begin
						state <= dmac_pkg::XFER_ROWS;
						sync_start <= desc_sync_transfer_start;
					end
				end
				dmac_pkg::XFER_ROWS: begin
					if (row_accept) begin
						sync_start <= 1'b0; // First row only.
						if (y_length == '0)
							state <= dmac_pkg::XFER_IDLE;
					end
				end
				default: state <= dmac_pkg::XFER_IDLE;
			endcase
		end
	end

	always_ff @(posedge req_aclk) begin
		if (!req_aresetn) begin
			issue_id <= '0;
			done_id <= '0;
			inflight <= '0;
			req_eot <= 1'b0;
		end else begin
			req_eot <= 1'b0;
			if (row_accept)
				issue_id <= issue_id + 1'b1;
			if (row_done) begin
				done_id <= done_id + 1'b1;
				req_eot <= last_row[done_id];
			end
			case ({row_accept, row_done})
				2'b10: inflight <= inflight + 1'b1;
				2'b01: inflight <= inflight - 1'b1;
				default: inflight <= inflight;
			endcase
		end
	end

endmodule

// ==== verilog/dmac_burst_splitter.sv ====
`include "dmac_macros.svh"

module dmac_burst_splitter (
	input logic req_aclk,
	input logic req_aresetn,

	input logic row_valid,
	output logic row_ready,
	input dmac_pkg::dmac_addr_t row_dest_address,
	input dmac_pkg::dmac_addr_t row_src_address,
	input dmac_pkg::dmac_length_t row_length,
	input logic row_sync_transfer_start,

	output logic burst_valid,
	input logic burst_ready,
	output dmac_pkg::dmac_addr_t burst_dest_address,
	output dmac_pkg::dmac_addr_t burst_src_address,
	output dmac_pkg::dmac_beats_t burst_beats,
	output logic burst_sync_transfer_start,

	input logic burst_done,
	output logic row_done
);

	localparam int ROW_BEATS_WIDTH = `DMAC_LENGTH_WIDTH - `DMAC_BEAT_WIDTH;

	dmac_pkg::split_state_e state;

	dmac_pkg::dmac_addr_t dest_address;
	dmac_pkg::dmac_addr_t src_address;
	logic [ROW_BEATS_WIDTH-1:0] beats_left; // Beats still to issue, minus one.
	logic sync_start;
	logic last_burst;
	logic burst_accept;

	// --------------------------------------------------
	// Bursts in flight
	// --------------------------------------------------
	dmac_pkg::dmac_id_t issue_id;
	dmac_pkg::dmac_id_t done_id;
	logic last_table [2**`DMAC_ID_WIDTH];
	logic [`DMAC_ID_WIDTH:0] inflight;

	assign last_burst = beats_left < ROW_BEATS_WIDTH'(`DMAC_MAX_BURST_BEATS);
	assign row_ready = state == dmac_pkg::SPLIT_IDLE;
	assign burst_valid = (state == dmac_pkg::SPLIT_ISSUE) && !inflight[`DMAC_ID_WIDTH];
	assign burst_accept = burst_valid && burst_ready;

	assign burst_dest_address = dest_address;
	assign burst_src_address = src_address;
	assign burst_sync_transfer_start = sync_start;
	assign burst_beats = last_burst ? dmac_pkg::dmac_beats_t'(beats_left) :
		dmac_pkg::dmac_beats_t'(`DMAC_MAX_BURST_BEATS - 1);

	always_ff @(posedge req_aclk) begin
		if (row_valid && row_ready) begin
			dest_address <= row_dest_address;
			src_address <= row_src_address;
			beats_left <= row_length[`DMAC_LENGTH_WIDTH-1:`DMAC_BEAT_WIDTH];
		end else if (burst_accept) begin
			dest_address <= dest_address + dmac_pkg::dmac_addr_t'(`DMAC_MAX_BURST_BEATS);
			src_address <= src_address + dmac_pkg::dmac_addr_t'(`DMAC_MAX_BURST_BEATS);
			beats_left <= beats_left - ROW_BEATS_WIDTH'(`DMAC_MAX_BURST_BEATS);
		end
		if (burst_accept)
			last_table[issue_id] <= last_burst;
	end

	always_ff @(posedge req_aclk) begin
		if (!req_aresetn) begin
			state <= dmac_pkg::SPLIT_IDLE;
			sync_start <= 1'b0;
		end else begin
			case (state)
				dmac_pkg::SPLIT_IDLE: begin
					if (row_valid) begin
						state <= dmac_pkg::SPLIT_ISSUE;
						sync_start <= row_sync_transfer_start;
					end
				end
				dmac_pkg::SPLIT_ISSUE: begin
					if (burst_accept) begin
						sync_start <= 1'b0;
						if (last_burst)
							state <= dmac_pkg::SPLIT_IDLE;
					end
				end
				default: state <= dmac_pkg::SPLIT_IDLE;
			endcase
		end
	end

	// Completions come back in issue order, so a plain counter finds the entry.
	always_ff @(posedge req_aclk) begin
		if (!req_aresetn) begin
			issue_id <= '0;
			done_id <= '0;
			inflight <= '0;
			row_done <= 1'b0;
		end else begin
			row_done <= 1'b0;
			if (burst_accept)
				issue_id <= issue_id + 1'b1;
			if (burst_done) begin
				done_id <= done_id + 1'b1;
				row_done <= last_table[done_id];
			end
			case ({burst_accept, burst_done})
				2'b10: inflight <= inflight + 1'b1;
				2'b01: inflight <= inflight - 1'b1;
				default: inflight <= inflight;
			endcase
		end
	end

endmodule

// ==== verilog/dmac_pkg.sv ====
`include "dmac_macros.svh"

package dmac_pkg;

	// --------------------------------------------------
	// Data types
	// --------------------------------------------------
	typedef logic [31:`DMAC_BEAT_WIDTH] dmac_addr_t; // Address in beats.
	typedef logic [`DMAC_LENGTH_WIDTH-1:0] dmac_length_t;

	// Beats in one burst, minus one.
	typedef logic [$clog2(`DMAC_MAX_BURST_BEATS)-1:0] dmac_beats_t;

	typedef logic [`DMAC_ID_WIDTH-1:0] dmac_id_t;

	// --------------------------------------------------
	// State machines
	// --------------------------------------------------
	typedef enum logic {
		XFER_IDLE,
		XFER_ROWS
	} xfer_state_e;

	typedef enum logic {
		SPLIT_IDLE,
		SPLIT_ISSUE
	} split_state_e;

endpackage

// ==== verilog/dmac_request_path.sv ====
module dmac_request_path (
	input logic req_aclk,
	input logic req_aresetn,

	input logic req_valid,
	output logic req_ready,
	input dmac_pkg::dmac_addr_t req_dest_address,
	input dmac_pkg::dmac_addr_t req_src_address,
	input dmac_pkg::dmac_length_t req_x_length,
	input dmac_pkg::dmac_length_t req_y_length,
	input dmac_pkg::dmac_length_t req_dest_stride,
	input dmac_pkg::dmac_length_t req_src_stride,
	input logic req_sync_transfer_start,
	output logic req_eot,

	output logic burst_valid,
	input logic burst_ready,
	output dmac_pkg::dmac_addr_t burst_dest_address,
	output dmac_pkg::dmac_addr_t burst_src_address,
	output dmac_pkg::dmac_beats_t burst_beats,
	output logic burst_sync_transfer_start,
	input logic burst_done
);

	// --------------------------------------------------
	// Queue to 2D transfer
	// --------------------------------------------------
	logic desc_valid;
	logic desc_ready;
	dmac_pkg::dmac_addr_t desc_dest_address;
	dmac_pkg::dmac_addr_t desc_src_address;
	dmac_pkg::dmac_length_t desc_x_length;
	dmac_pkg::dmac_length_t desc_y_length;
	dmac_pkg::dmac_length_t desc_dest_stride;
	dmac_pkg::dmac_length_t desc_src_stride;
	logic desc_sync_transfer_start;

	// --------------------------------------------------
	// 2D transfer to burst splitter
	// --------------------------------------------------
	logic row_valid;
	logic row_ready;
	dmac_pkg::dmac_addr_t row_dest_address;
	dmac_pkg::dmac_addr_t row_src_address;
	dmac_pkg::dmac_length_t row_length;
	logic row_sync_transfer_start;
	logic row_done; // Back from the splitter, one per row.

	dmac_request_queue dmac_request_queue_inst (
		.req_aclk(req_aclk),
		.req_aresetn(req_aresetn),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_dest_address(req_dest_address),
		.req_src_address(req_src_address),
		.req_x_length(req_x_length),
		.req_y_length(req_y_length),
		.req_dest_stride(req_dest_stride),
		.req_src_stride(req_src_stride),
		.req_sync_transfer_start(req_sync_transfer_start),
		.desc_valid(desc_valid),
		.desc_ready(desc_ready),
		.desc_dest_address(desc_dest_address),
		.desc_src_address(desc_src_address),
		.desc_x_length(desc_x_length),
		.desc_y_length(desc_y_length),
		.desc_dest_stride(desc_dest_stride),
		.desc_src_stride(desc_src_stride),
		.desc_sync_transfer_start(desc_sync_transfer_start)
	);

	dmac_2d_transfer dmac_2d_transfer_inst (
		.req_aclk(req_aclk),
		.req_aresetn(req_aresetn),
		.desc_valid(desc_valid),
		.desc_ready(desc_ready),
		.desc_dest_address(desc_dest_address),
		.desc_src_address(desc_src_address),
		.desc_x_length(desc_x_length),
		.desc_y_length(desc_y_length),
		.desc_dest_stride(desc_dest_stride),
		.desc_src_stride(desc_src_stride),
		.desc_sync_transfer_start(desc_sync_transfer_start),
		.row_valid(row_valid),
		.row_ready(row_ready),
		.row_dest_address(row_dest_address),
		.row_src_address(row_src_address),
		.row_length(row_length),
		.row_sync_transfer_start(row_sync_transfer_start),
		.row_done(row_done),
		.req_eot(req_eot)
	);

	dmac_burst_splitter dmac_burst_splitter_inst (
		.req_aclk(req_aclk),
		.req_aresetn(req_aresetn),
		.row_valid(row_valid),
		.row_ready(row_ready),
		.row_dest_address(row_dest_address),
		.row_src_address(row_src_address),
		.row_length(row_length),
		.row_sync_transfer_start(row_sync_transfer_start),
		.burst_valid(burst_valid),
		.burst_ready(burst_ready),
		.burst_dest_address(burst_dest_address),
		.burst_src_address(burst_src_address),
		.burst_beats(burst_beats),
		.burst_sync_transfer_start(burst_sync_transfer_start),
		.burst_done(burst_done),
		.row_done(row_done)
	);

endmodule

// ==== verilog/dmac_request_queue.sv ====
`include "dmac_macros.svh"

module dmac_request_queue (
	input logic req_aclk,
	input logic req_aresetn,

	input logic req_valid,
	output logic req_ready,
	input dmac_pkg::dmac_addr_t req_dest_address,
	input dmac_pkg::dmac_addr_t req_src_address,
	input dmac_pkg::dmac_length_t req_x_length,
	input dmac_pkg::dmac_length_t req_y_length,
	input dmac_pkg::dmac_length_t req_dest_stride,
	input dmac_pkg::dmac_length_t req_src_stride,
	input logic req_sync_transfer_start,

	output logic desc_valid,
	input logic desc_ready,
	output dmac_pkg::dmac_addr_t desc_dest_address,
	output dmac_pkg::dmac_addr_t desc_src_address,
	output dmac_pkg::dmac_length_t desc_x_length,
	output dmac_pkg::dmac_length_t desc_y_length,
	output dmac_pkg::dmac_length_t desc_dest_stride,
	output dmac_pkg::dmac_length_t desc_src_stride,
	output logic desc_sync_transfer_start
);

	localparam int PTR_WIDTH = $clog2(`DMAC_QUEUE_DEPTH);
	localparam int COUNT_WIDTH = $clog2(`DMAC_QUEUE_DEPTH + 1);

	dmac_pkg::dmac_addr_t dest_mem [`DMAC_QUEUE_DEPTH];
	dmac_pkg::dmac_addr_t src_mem [`DMAC_QUEUE_DEPTH];
	dmac_pkg::dmac_length_t x_mem [`DMAC_QUEUE_DEPTH];
	dmac_pkg::dmac_length_t y_mem [`DMAC_QUEUE_DEPTH];
	dmac_pkg::dmac_length_t dest_stride_mem [`DMAC_QUEUE_DEPTH];
	dmac_pkg::dmac_length_t src_stride_mem [`DMAC_QUEUE_DEPTH];
	logic sync_mem [`DMAC_QUEUE_DEPTH];

	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic push;
	logic pop;

	assign req_ready = count != COUNT_WIDTH'(`DMAC_QUEUE_DEPTH);
	assign desc_valid = count != '0;
	assign push = req_valid && req_ready;
	assign pop = desc_valid && desc_ready;

	// The head entry is presented directly from storage.
	assign desc_dest_address = dest_mem[rd_ptr];
	assign desc_src_address = src_mem[rd_ptr];
	assign desc_x_length = x_mem[rd_ptr];
	assign desc_y_length = y_mem[rd_ptr];
	assign desc_dest_stride = dest_stride_mem[rd_ptr];
	assign desc_src_stride = src_stride_mem[rd_ptr];
	assign desc_sync_transfer_start = sync_mem[rd_ptr];

	always_ff @(posedge req_aclk) begin
		if (push) begin
			dest_mem[wr_ptr] <= req_dest_address;
			src_mem[wr_ptr] <= req_src_address;
			x_mem[wr_ptr] <= req_x_length;
			y_mem[wr_ptr] <= req_y_length;
			dest_stride_mem[wr_ptr] <= req_dest_stride;
			src_stride_mem[wr_ptr] <= req_src_stride;
			sync_mem[wr_ptr] <= req_sync_transfer_start;
		end
	end

	always_ff @(posedge req_aclk) begin
		if (!req_aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_WIDTH'(`DMAC_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_WIDTH'(`DMAC_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither.
			endcase
		end
	end

endmodule
